// File: line_cfg.svh
// Build-time sizing for the line rasterizer
// Include wherever engine count or bus widths are needed
`ifndef LINE_CFG_SVH
`define LINE_CFG_SVH

// Parallel stepping engines
`define LR_NUM_ENGINES 4
// Pixel coordinate and colour widths
`define LR_COORD_W 10
`define LR_COLOR_W 16
// Framebuffer row length in pixels, word address width
`define LR_FB_WIDTH 640
`define LR_FB_ADDR_W 19

`endif

// File: line_pkg.sv
// Shared types for the line rasterizer
// Host register map and the command handed to each engine
`include "line_cfg.svh"

package line_pkg;

	// Unsigned screen coordinate
	typedef logic [`LR_COORD_W-1:0] coord_t;
	typedef logic [`LR_COLOR_W-1:0] color_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} point_t;

	// Start point, end point, colour
	typedef struct packed {
		point_t p0;
		point_t p1;
		color_t color;
	} line_cmd_t;

	// Host offsets on the 3-bit Wishbone address
	typedef enum logic [2:0] {
		REG_X0 = 3'd0,
		REG_Y0 = 3'd1,
		REG_X1 = 3'd2,
		REG_Y1 = 3'd3,
		REG_COLOR = 3'd4,
		REG_GO = 3'd5,
		REG_STATUS = 3'd6
	} host_reg_e;

endpackage

// File: pixel_if.sv
// Pixel stream from one line engine to the pixel writer
// Valid/ready handshake, payload held while stalled
`timescale 1ns/100ps

interface pixel_if;

	// Handshake
	logic valid;
	logic ready;
	// Payload
	line_pkg::coord_t x;
	line_pkg::coord_t y;
	line_pkg::color_t color;
	// End point of the line
	logic last;

	// Engine side
	modport source (output valid, output x, output y, output color, output last,
		input ready);

	// Writer side
	modport sink (input valid, input x, input y, input color, input last,
		output ready);

endinterface

// File: line_cmd_slave.sv
// Host-facing Wishbone classic slave
// Stages endpoints and colour, GO hands the line to the lowest free engine
`timescale 1ns/100ps
`include "line_cfg.svh"

module line_cmd_slave
(
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [2:0] adr,
	input logic [15:0] dat_w,
	input logic [`LR_NUM_ENGINES-1:0] busy,
	output logic [15:0] dat_r,
	output logic ack,
	output logic [`LR_NUM_ENGINES-1:0] load,
	output line_pkg::line_cmd_t cmd
);
	localparam int N = `LR_NUM_ENGINES;

	// Staging registers
	line_pkg::coord_t x0_q;
	line_pkg::coord_t y0_q;
	line_pkg::coord_t x1_q;
	line_pkg::coord_t y1_q;
	line_pkg::color_t color_q;

	logic acc;
	logic go_wr;
	logic acc_ok;
	logic [N-1:0] free;
	logic [N-1:0] free_oh;
	logic [15:0] rd_mux;

	// New access, not yet acknowledged
	assign acc = cyc && stb && !ack;
	assign go_wr = acc && we && (adr == 3'(line_pkg::REG_GO));

	// Lowest set bit of the free mask
	assign free = ~busy;
	assign free_oh = free & (~free + 1'b1);

	// GO waits here until some engine is idle
	assign acc_ok = acc && (!go_wr || (free != '0));
	assign load = (go_wr && (free != '0)) ? free_oh : '0;

	assign cmd.p0.x = x0_q;
	assign cmd.p0.y = y0_q;
	assign cmd.p1.x = x1_q;
	assign cmd.p1.y = y1_q;
	assign cmd.color = color_q;

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			ack <= 1'b0;
			x0_q <= '0;
			y0_q <= '0;
			x1_q <= '0;
			y1_q <= '0;
			color_q <= '0;
		end
		else
		begin
			// Single-cycle ack per access
			ack <= acc_ok;
			if (acc_ok && we)
			begin
				case (line_pkg::host_reg_e'(adr))
					line_pkg::REG_X0: x0_q <= dat_w[`LR_COORD_W-1:0];
					line_pkg::REG_Y0: y0_q <= dat_w[`LR_COORD_W-1:0];
					line_pkg::REG_X1: x1_q <= dat_w[`LR_COORD_W-1:0];
					line_pkg::REG_Y1: y1_q <= dat_w[`LR_COORD_W-1:0];
					line_pkg::REG_COLOR: color_q <= dat_w[`LR_COLOR_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// Read mux, GO and unused offsets read as zero
	always_comb
	begin
		case (line_pkg::host_reg_e'(adr))
			line_pkg::REG_X0: rd_mux = 16'(x0_q);
			line_pkg::REG_Y0: rd_mux = 16'(y0_q);
			line_pkg::REG_X1: rd_mux = 16'(x1_q);
			line_pkg::REG_Y1: rd_mux = 16'(y1_q);
			line_pkg::REG_COLOR: rd_mux = 16'(color_q);
			line_pkg::REG_STATUS: rd_mux = 16'(busy);
			default: rd_mux = '0;
		endcase
	end

	// Read data captured on the ack edge
	always_ff @(posedge clk)
	begin
		if (acc_ok && !we)
			dat_r <= rd_mux;
	end

	// Host keeps the strobe up until it samples ack
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!reset)
		ack |-> (cyc && stb));

	// Never two engines loaded at once
	a_load_onehot: assert property (@(posedge clk) disable iff (!reset)
		$onehot0(load));

endmodule

// File: line_engine.sv
// Bresenham line stepper, all octants, both endpoints drawn
// Load latches a command, then one pixel per accepted handshake
`timescale 1ns/100ps
`include "line_cfg.svh"

module line_engine
(
	input logic clk,
	input logic reset,
	input logic load,
	input line_pkg::line_cmd_t cmd,
	output logic busy,
	pixel_if.source pix
);
	// Error term width, headroom for doubling
	localparam int EW = `LR_COORD_W + 3;

	logic active;
	logic accept;

	// Line state
	line_pkg::point_t cur_q;
	line_pkg::point_t end_q;
	line_pkg::color_t color_q;
	logic sx_neg_q;
	logic sy_neg_q;
	logic signed [EW-1:0] dx_q;
	logic signed [EW-1:0] dy_q;
	logic signed [EW-1:0] err_q;

	// Load-time and step-time arithmetic
	line_pkg::coord_t abs_dx;
	line_pkg::coord_t abs_dy;
	logic signed [EW-1:0] dx_init;
	logic signed [EW-1:0] dy_init;
	logic signed [EW:0] e2;
	logic step_x;
	logic step_y;

	always_comb
	begin
		abs_dx = (cmd.p1.x >= cmd.p0.x) ? cmd.p1.x - cmd.p0.x : cmd.p0.x - cmd.p1.x;
		abs_dy = (cmd.p1.y >= cmd.p0.y) ? cmd.p1.y - cmd.p0.y : cmd.p0.y - cmd.p1.y;
		// dx positive, dy negative
		dx_init = EW'(abs_dx);
		dy_init = -EW'(abs_dy);
	end

	// Doubled error decides which axes move
	assign e2 = {err_q, 1'b0};
	assign step_x = (e2 >= dy_q);
	assign step_y = (e2 <= dx_q);

	// Stream outputs straight from the state
	assign pix.valid = active;
	assign pix.x = cur_q.x;
	assign pix.y = cur_q.y;
	assign pix.color = color_q;
	assign pix.last = active && (cur_q == end_q);
	assign accept = pix.valid && pix.ready;
	assign busy = active;

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
			active <= 1'b0;
		else if (load)
			active <= 1'b1;
		// Idle once the end point is taken
		else if (accept && pix.last)
			active <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			cur_q <= cmd.p0;
			end_q <= cmd.p1;
			color_q <= cmd.color;
			sx_neg_q <= (cmd.p1.x < cmd.p0.x);
			sy_neg_q <= (cmd.p1.y < cmd.p0.y);
			dx_q <= dx_init;
			dy_q <= dy_init;
			err_q <= dx_init + dy_init;
		end
		else if (accept && !pix.last)
		begin
			// Advance to the next point
			if (step_x)
				cur_q.x <= sx_neg_q ? cur_q.x - 1'b1 : cur_q.x + 1'b1;
			if (step_y)
				cur_q.y <= sy_neg_q ? cur_q.y - 1'b1 : cur_q.y + 1'b1;
			err_q <= err_q + (step_x ? dy_q : '0) + (step_y ? dx_q : '0);
		end
	end

	// Stalled pixel stays put until the writer takes it
	a_hold_stall: assert property (@(posedge clk) disable iff (!reset)
		(pix.valid && !pix.ready) |=>
		(pix.valid && $stable({pix.x, pix.y, pix.color, pix.last})));

	// Slave only dispatches to idle engines
	a_load_idle: assert property (@(posedge clk) disable iff (!reset)
		load |-> !busy);

endmodule

// File: pixel_writer.sv
// Drains all engine pixel streams into framebuffer writes
// Round-robin pick, one pixel buffered, Wishbone classic master
`timescale 1ns/100ps
`include "line_cfg.svh"

module pixel_writer
(
	input logic clk,
	input logic reset,
	pixel_if.sink pix [`LR_NUM_ENGINES],
	input logic fb_ack,
	output logic fb_cyc,
	output logic fb_stb,
	output logic fb_we,
	output logic [`LR_FB_ADDR_W-1:0] fb_adr,
	output line_pkg::color_t fb_dat_w
);
	localparam int N = `LR_NUM_ENGINES;
	localparam int SW = (N > 1) ? $clog2(N) : 1;
	localparam int AW = `LR_FB_ADDR_W;

	// Flattened view of the streams
	logic [N-1:0] valid_v;
	line_pkg::coord_t x_a [N];
	line_pkg::coord_t y_a [N];
	line_pkg::color_t color_a [N];

	logic [SW-1:0] rr_q;
	logic [SW-1:0] sel;
	logic any_valid;
	logic pend_q;
	logic cyc_q;
	logic done;
	logic take;
	logic [AW-1:0] adr_q;
	line_pkg::color_t dat_q;

	for (genvar g = 0; g < N; g++)
	begin : g_port
		assign valid_v[g] = pix[g].valid;
		assign x_a[g] = pix[g].x;
		assign y_a[g] = pix[g].y;
		assign color_a[g] = pix[g].color;
		// Only the chosen engine sees ready
		assign pix[g].ready = take && (sel == SW'(g));
	end

	// First valid engine after the last one served
	always_comb
	begin
		sel = rr_q;
		any_valid = 1'b0;
		for (int i = 1; i <= N; i++)
		begin
			if (!any_valid && valid_v[(int'(rr_q) + i) % N])
			begin
				sel = SW'((int'(rr_q) + i) % N);
				any_valid = 1'b1;
			end
		end
	end

	// Buffer free, or freed on this ack
	assign done = cyc_q && fb_ack;
	assign take = any_valid && (!pend_q || done);

	always_ff @(posedge clk, negedge reset)
	begin
		if (!reset)
		begin
			rr_q <= SW'(N - 1);
			pend_q <= 1'b0;
			cyc_q <= 1'b0;
		end
		else
		begin
			if (take)
			begin
				pend_q <= 1'b1;
				rr_q <= sel;
			end
			else if (done)
				pend_q <= 1'b0;
			// Cycle opens the edge after a pixel is buffered
			if (done)
				cyc_q <= 1'b0;
			else if (pend_q)
				cyc_q <= 1'b1;
		end
	end

	// Row-major word address
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			adr_q <= AW'(y_a[sel]) * AW'(`LR_FB_WIDTH) + AW'(x_a[sel]);
			dat_q <= color_a[sel];
		end
	end

	assign fb_cyc = cyc_q;
	assign fb_stb = cyc_q;
	assign fb_we = cyc_q;
	assign fb_adr = adr_q;
	assign fb_dat_w = dat_q;

	// Open cycle keeps its address and data until ack
	a_fb_stable: assert property (@(posedge clk) disable iff (!reset)
		(fb_cyc && !fb_ack) |=> (fb_cyc && $stable(fb_adr) && $stable(fb_dat_w)));

endmodule

// File: line_raster_top.sv
// Top level of the parallel line rasterizer
// Host Wishbone slave in, framebuffer Wishbone master out
`timescale 1ns/100ps
`include "line_cfg.svh"

module line_raster_top
(
	input logic clk,
	input logic reset,
	// Host bus
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [2:0] adr,
	input logic [15:0] dat_w,
	output logic [15:0] dat_r,
	output logic ack,
	// Framebuffer bus
	output logic fb_cyc,
	output logic fb_stb,
	output logic fb_we,
	output logic [`LR_FB_ADDR_W-1:0] fb_adr,
	output line_pkg::color_t fb_dat_w,
	input logic fb_ack
);
	logic [`LR_NUM_ENGINES-1:0] load;
	logic [`LR_NUM_ENGINES-1:0] busy;
	line_pkg::line_cmd_t cmd;

	// One stream per engine
	pixel_if pix_bus [`LR_NUM_ENGINES] ();

	line_cmd_slave line_cmd_slave_i (.clk(clk), .reset(reset), .cyc(cyc), .stb(stb),
		.we(we), .adr(adr), .dat_w(dat_w), .busy(busy), .dat_r(dat_r), .ack(ack),
		.load(load), .cmd(cmd));

	// Engines share the command bus, load picks one
	for (genvar g = 0; g < `LR_NUM_ENGINES; g++)
	begin : g_engine
		line_engine line_engine_i (.clk(clk), .reset(reset), .load(load[g]), .cmd(cmd),
			.busy(busy[g]), .pix(pix_bus[g]));
	end

	pixel_writer pixel_writer_i (.clk(clk), .reset(reset), .pix(pix_bus),
		.fb_ack(fb_ack), .fb_cyc(fb_cyc), .fb_stb(fb_stb), .fb_we(fb_we),
		.fb_adr(fb_adr), .fb_dat_w(fb_dat_w));

endmodule

// File: tb_line_raster.sv
// Testbench for the parallel line rasterizer
// Drives the host Wishbone port, models the framebuffer with random ack delay
// and checks every line against a Bresenham reference list
`timescale 1ns/100ps
`include "line_cfg.svh"

module tb_line_raster;
	localparam int NUM_LINES = 16;

	logic clk = 1'b0;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [2:0] adr;
	logic [15:0] dat_w;
	logic [15:0] dat_r;
	logic ack;
	logic fb_cyc;
	logic fb_stb;
	logic fb_we;
	logic [`LR_FB_ADDR_W-1:0] fb_adr;
	line_pkg::color_t fb_dat_w;
	logic fb_ack;

	// Lines as x0, y0, x1, y1
	// 0..7 octants, 8..10 special cases, 11..14 concurrent, 15 stalled GO
	int line_tab [NUM_LINES][4] = '{
		'{300, 200, 340, 215}, '{300, 200, 315, 240}, '{300, 200, 285, 240},
		'{300, 200, 260, 215}, '{300, 200, 260, 185}, '{300, 200, 285, 160},
		'{300, 200, 315, 160}, '{300, 200, 340, 185}, '{10, 10, 50, 10},
		'{600, 20, 600, 60}, '{5, 5, 5, 5}, '{20, 300, 220, 350},
		'{400, 100, 250, 300}, '{630, 470, 450, 420}, '{100, 470, 60, 270},
		'{50, 50, 90, 80}};
	string line_name [NUM_LINES] = '{"octant_1", "octant_2", "octant_3", "octant_4",
		"octant_5", "octant_6", "octant_7", "octant_8", "horizontal", "vertical",
		"single_point", "concurrent_0", "concurrent_1", "concurrent_2", "concurrent_3",
		"stalled_line"};

	// Framebuffer write log in arrival order
	int fb_adr_log [$];
	line_pkg::color_t fb_col_log [$];
	int exp_adr [$];
	int act_adr [$];
	int exp_total = 0;
	int errors = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	logic [31:0] lfsr = 32'h67a3;

	always #20 clk = ~clk;

	line_raster_top line_raster_top_i (.clk(clk), .reset(reset), .cyc(cyc), .stb(stb),
		.we(we), .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack), .fb_cyc(fb_cyc),
		.fb_stb(fb_stb), .fb_we(fb_we), .fb_adr(fb_adr), .fb_dat_w(fb_dat_w),
		.fb_ack(fb_ack));

	// Framebuffer strobe only inside a cycle
	a_fb_stb_cyc: assert property (@(posedge clk) disable iff (!reset)
		fb_stb |-> fb_cyc)
	else
	begin
		errors++;
		$display("fb_stb was high without fb_cyc at %0t", $time);
	end

	// Every framebuffer cycle is a write
	a_fb_we_cyc: assert property (@(posedge clk) disable iff (!reset)
		fb_cyc |-> fb_we)
	else
	begin
		errors++;
		$display("fb_we was low during a framebuffer cycle at %0t", $time);
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++)
			v = (v << 1) | int'(lfsr_step());
		return v;
	endfunction

	function automatic line_pkg::color_t line_color(int i);
		return 16'(16'h1100 + i * 16'h0103);
	endfunction

	// Larger axis span plus one
	function automatic int pix_count(int i);
		int adx;
		int ady;
		adx = line_tab[i][2] - line_tab[i][0];
		ady = line_tab[i][3] - line_tab[i][1];
		if (adx < 0)
			adx = -adx;
		if (ady < 0)
			ady = -ady;
		return ((adx > ady) ? adx : ady) + 1;
	endfunction

	// Reference Bresenham walk into exp_adr
	task automatic ref_line(int i);
		int x;
		int y;
		int dx;
		int dy;
		int sx;
		int sy;
		int err;
		int e2;
		x = line_tab[i][0];
		y = line_tab[i][1];
		dx = (line_tab[i][2] >= x) ? line_tab[i][2] - x : x - line_tab[i][2];
		dy = (line_tab[i][3] >= y) ? y - line_tab[i][3] : line_tab[i][3] - y;
		sx = (line_tab[i][2] >= x) ? 1 : -1;
		sy = (line_tab[i][3] >= y) ? 1 : -1;
		err = dx + dy;
		exp_adr.delete();
		while (1)
		begin
			exp_adr.push_back(y * `LR_FB_WIDTH + x);
			if (x == line_tab[i][2] && y == line_tab[i][3])
				break;
			e2 = 2 * err;
			if (e2 >= dy)
			begin
				err += dy;
				x += sx;
			end
			if (e2 <= dx)
			begin
				err += dx;
				y += sy;
			end
		end
	endtask

	task automatic check_eq(string name, int exp, int act);
		assert (exp == act)
		else
		begin
			errors++;
			$display("mismatch %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Caller sits 2 ns after an edge and returns at the same phase
	task automatic bus_access(input logic write, input line_pkg::host_reg_e r, input int d,
		output logic [15:0] rd, output int waits);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = r;
		dat_w = 16'(d);
		waits = 0;
		@(posedge clk);
		#1;
		while (!ack)
		begin
			waits++;
			@(posedge clk);
			#1;
		end
		rd = dat_r;
		// Strobe held through the edge that samples ack
		@(posedge clk);
		#2;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic reg_write(line_pkg::host_reg_e r, int d);
		logic [15:0] rd;
		int w;
		bus_access(1'b1, r, d, rd, w);
	endtask

	task automatic reg_read(input line_pkg::host_reg_e r, output logic [15:0] rd);
		int w;
		bus_access(1'b0, r, 0, rd, w);
	endtask

	task automatic start_line(input int i, output int waits);
		logic [15:0] rd;
		reg_write(line_pkg::REG_X0, line_tab[i][0]);
		reg_write(line_pkg::REG_Y0, line_tab[i][1]);
		reg_write(line_pkg::REG_X1, line_tab[i][2]);
		reg_write(line_pkg::REG_Y1, line_tab[i][3]);
		reg_write(line_pkg::REG_COLOR, int'(line_color(i)));
		bus_access(1'b1, line_pkg::REG_GO, 0, rd, waits);
	endtask

	// Writes of one colour in order against the reference
	task automatic check_line(int i);
		int n;
		act_adr.delete();
		foreach (fb_col_log[k])
			if (fb_col_log[k] == line_color(i))
				act_adr.push_back(fb_adr_log[k]);
		ref_line(i);
		check_eq({line_name[i], " count"}, pix_count(i), act_adr.size());
		n = (exp_adr.size() < act_adr.size()) ? exp_adr.size() : act_adr.size();
		for (int k = 0; k < n; k++)
			check_eq($sformatf("%s pixel %0d", line_name[i], k), exp_adr[k], act_adr[k]);
	endtask

	task automatic wait_writes();
		while (fb_adr_log.size() < exp_total)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic end_test(string name, int n_err);
		if (n_err == 0)
		begin
			pass_cnt++;
			$display("%s: ok", name);
		end
		else
		begin
			fail_cnt++;
			$display("%s: %0d errors", name, n_err);
		end
	endtask

	// Framebuffer slave with 0 to 3 cycles of ack delay
	initial
	begin
		int dly;
		fb_ack = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			if (fb_cyc && fb_stb)
			begin
				dly = rand_bits(2);
				if (dly == 0)
					#1;
				else
				begin
					repeat (dly) @(posedge clk);
					#2;
				end
				fb_ack = 1'b1;
				fb_adr_log.push_back(int'(fb_adr));
				fb_col_log.push_back(fb_dat_w);
				@(posedge clk);
				#2;
				fb_ack = 1'b0;
			end
		end
	end

	// Watchdog sized from the pixel total
	initial
	begin
		int limit;
		limit = 2000;
		for (int i = 0; i < NUM_LINES; i++)
			limit += 200 * pix_count(i);
		repeat (limit) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		logic [15:0] rd;
		int waits;
		int e0;
		int c_pre;
		int d_pre;
		int done_any;
		int wr_vals [5] = '{123, 45, 678, 400, 16'hbeef};
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		reset = 1'b0;
		repeat (10) @(posedge clk);
		#2;
		reset = 1'b1;
		@(posedge clk);
		#2;

		// Staging registers and idle status
		e0 = errors;
		reg_read(line_pkg::REG_STATUS, rd);
		check_eq("register_readback status", 0, int'(rd));
		for (int k = 0; k < 5; k++)
			reg_write(line_pkg::host_reg_e'(k), wr_vals[k]);
		for (int k = 0; k < 5; k++)
		begin
			reg_read(line_pkg::host_reg_e'(k), rd);
			check_eq($sformatf("register_readback reg %0d", k), wr_vals[k], int'(rd));
		end
		end_test("register_readback", errors - e0);

		// One line at a time
		for (int i = 0; i < 11; i++)
		begin
			e0 = errors;
			start_line(i, waits);
			exp_total += pix_count(i);
			wait_writes();
			check_line(i);
			check_eq({line_name[i], " total writes"}, exp_total, fb_adr_log.size());
			end_test(line_name[i], errors - e0);
		end

		// Four lines in flight together
		e0 = errors;
		for (int i = 11; i < 15; i++)
		begin
			start_line(i, waits);
			exp_total += pix_count(i);
		end
		reg_read(line_pkg::REG_STATUS, rd);
		check_eq("concurrent_lines busy mask", 15, int'(rd));
		c_pre = errors - e0;

		// Fifth GO must wait for an engine to drain
		e0 = errors;
		start_line(15, waits);
		exp_total += pix_count(15);
		done_any = 0;
		for (int i = 11; i < 15; i++)
		begin
			act_adr.delete();
			foreach (fb_col_log[k])
				if (fb_col_log[k] == line_color(i))
					act_adr.push_back(fb_adr_log[k]);
			if (act_adr.size() >= pix_count(i) - 1)
				done_any = 1;
		end
		if (waits == 0 || done_any == 0)
		begin
			errors++;
			$display("GO write was acknowledged while all four engines were busy");
		end
		d_pre = errors - e0;

		wait_writes();
		e0 = errors;
		for (int i = 11; i < 15; i++)
			check_line(i);
		end_test("concurrent_lines", c_pre + errors - e0);
		e0 = errors;
		check_line(15);
		end_test("dispatch_stall", d_pre + errors - e0);

		// Nothing dropped or repeated under random ack delay
		e0 = errors;
		repeat (40) @(posedge clk);
		#2;
		check_eq("fb_backpressure total writes", exp_total, fb_adr_log.size());
		end_test("fb_backpressure", errors - e0);

		e0 = errors;
		reg_read(line_pkg::REG_STATUS, rd);
		check_eq("completion status", 0, int'(rd));
		end_test("completion", errors - e0);

		$display("summary: %0d tests ok, %0d tests failing, %0d errors",
			pass_cnt, fail_cnt, errors);
		if (fail_cnt == 0 && errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+.
line_pkg.sv
pixel_if.sv
line_cmd_slave.sv
line_engine.sv
pixel_writer.sv
line_raster_top.sv
tb_line_raster.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the line rasterizer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_line_raster --Mdir obj_dir -o tb_line_raster
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_line_raster)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Test passed$" <<< "$output"; then
	exit 0
fi
exit 1
